// ==== compile.f ====
+incdir+common
common/pit_bus_pkg.sv
common/pit_count_pkg.sv
design/bus_decoder.sv
counter/count_access.sv
counter/count_engine.sv
design/pit_top.sv
verification/pit_chk.sv
verification/pit_tb.sv

// ==== Makefile ====
# Verilator build and run of the interval timer testbench
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = pit_tb
FILELIST = compile.f

OBJ_DIR = obj_dir
SIM = $(OBJ_DIR)/V$(TOP)
LOG = sim.log
SOURCES = $(shell grep -v '^+' $(FILELIST)) common/pit_config.svh

.PHONY: all run check clean

all: check

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)

check: run
	@grep -q "^test passed$$" $(LOG) && echo "PASS" || (echo "FAIL" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/pit_tb.sv ====
// Interval timer testbench
`timescale 1ns/1ps
`default_nettype none

`include "pit_config.svh"

module pit_tb
	import pit_bus_pkg::*;
	import pit_count_pkg::*;
();

	// Half of the 8 cycle tick spacing
	localparam int TICK_HALF = 4;
	// Limit well above the length of the test sequence
	localparam int TIMEOUT_CYCLES = 6000;
	localparam int SQ_INIT = 6;

	logic ZCLK;
	logic rst_n;
	logic cs_n;
	logic rd_n;
	logic wr_n;
	logic [1:0] addr;
	logic [`PIT_DATA_W-1:0] data_in;
	logic [`PIT_DATA_W-1:0] data_out;
	logic data_oe;
	logic [`PIT_NUM_COUNTERS-1:0] timer_clk;
	logic [`PIT_NUM_COUNTERS-1:0] gate;
	logic [`PIT_NUM_COUNTERS-1:0] out;

	int seed;
	int cycle_count = 0;
	int n0;
	int n1;
	int cnt;
	int b;
	logic [7:0] rd;

	pit_top u_pit_top (
		.ZCLK(ZCLK),
		.rst_n(rst_n),
		.cs_n(cs_n),
		.rd_n(rd_n),
		.wr_n(wr_n),
		.addr(addr),
		.data_in(data_in),
		.data_out(data_out),
		.data_oe(data_oe),
		.timer_clk(timer_clk),
		.gate(gate),
		.out(out)
	);

	initial begin
		ZCLK = 1'b0;
		forever #50 ZCLK = ~ZCLK;
	end

	always @(posedge ZCLK) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("simulation ran past %0d cycles without finishing", TIMEOUT_CYCLES);
			$display("test failed");
			$fatal(1);
		end
	end

	function automatic logic [7:0] mode_word(input logic [1:0] sel, input rw_order_t order,
		input logic [2:0] mode);
		mode_cmd_t cmd;
		cmd = '{sel: sel, order: order, mode: mode, bcd: 1'b0};
		return cmd;
	endfunction

	function automatic logic [7:0] latch_word(input logic [1:0] sel);
		latch_cmd_t cmd;
		cmd = '{sel: sel, zero: RW_LATCH, unused: 4'h0};
		return cmd;
	endfunction

	task automatic check_value(input string name, input int expected, input int actual);
		assert (expected == actual) else begin
			$display("error %s expected %0d actual %0d", name, expected, actual);
			$display("test failed");
			$fatal(1);
		end
	endtask

	// All bus tasks start and end on a falling edge
	task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
		cs_n = 1'b0;
		addr = a;
		data_in = d;
		wr_n = 1'b0;
		repeat (2) @(negedge ZCLK);
		wr_n = 1'b1;
		cs_n = 1'b1;
		repeat (2) @(negedge ZCLK);
	endtask

	task automatic bus_read(input string name, input logic [1:0] a, input logic cs,
		input logic oe_exp, output logic [7:0] d);
		cs_n = cs;
		addr = a;
		rd_n = 1'b0;
		@(negedge ZCLK);
		check_value({name, " oe"}, oe_exp, data_oe);
		@(negedge ZCLK);
		rd_n = 1'b1;
		cs_n = 1'b1;
		repeat (2) @(negedge ZCLK);
		d = data_out;
	endtask

	task automatic read_pair(input string name, input logic [1:0] a, input int expected);
		logic [7:0] lo;
		logic [7:0] hi;
		bus_read(name, a, 1'b0, 1'b1, lo);
		bus_read(name, a, 1'b0, 1'b1, hi);
		check_value({name, " lsb"}, expected & 8'hff, lo);
		check_value({name, " msb"}, (expected >> 8) & 8'hff, hi);
	endtask

	task automatic tick(input int ch);
		timer_clk[ch] = 1'b1;
		repeat (TICK_HALF) @(negedge ZCLK);
		timer_clk[ch] = 1'b0;
		repeat (TICK_HALF) @(negedge ZCLK);
	endtask

	initial begin
		seed = 32'h70f8530b;
		rst_n = 1'b0;
		cs_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		addr = 2'd0;
		data_in = '0;
		timer_clk = '0;
		gate = '1;
		repeat (2) @(negedge ZCLK);
		rst_n = 1'b1;
		@(negedge ZCLK);
		check_value("reset out", 7, out);
		check_value("reset oe", 0, data_oe);

		// Mode 0 on counter 0
		n0 = 5 + int'({$random(seed)} % 36);
		bus_write(CTRL_ADDR, mode_word(2'd0, RW_LSB_MSB, 3'd0));
		bus_write(2'd0, n0[7:0]);
		bus_write(2'd0, 8'h00);
		check_value("mode0 load", 0, out[0]);
		repeat (n0) tick(0);
		check_value("mode0 n ticks", 0, out[0]);
		tick(0);
		check_value("mode0 terminal", 1, out[0]);
		repeat (3) tick(0);
		check_value("mode0 hold", 1, out[0]);

		// Latch on counter 1 where mode 1 behaves as mode 0
		n1 = 5 + int'({$random(seed)} % 36);
		bus_write(CTRL_ADDR, mode_word(2'd1, RW_LSB_MSB, 3'd1));
		bus_write(2'd1, n1[7:0]);
		bus_write(2'd1, 8'h00);
		repeat (3) tick(1);
		bus_write(CTRL_ADDR, latch_word(2'd1));
		read_pair("latch c1", 2'd1, n1 - 2);
		repeat (2) tick(1);
		read_pair("held c1", 2'd1, n1 - 2);

		// Square wave on counter 2
		bus_write(CTRL_ADDR, mode_word(2'd2, RW_LSB_MSB, 3'd3));
		bus_write(2'd2, SQ_INIT[7:0]);
		bus_write(2'd2, 8'h00);
		tick(2);
		cnt = SQ_INIT;
		check_value("square load", 1, out[2]);
		for (int i = 0; i < 17; i++) begin
			tick(2);
			cnt = (cnt == 0) ? SQ_INIT : cnt - 1;
			check_value("square wave", (cnt > SQ_INIT / 2) ? 1 : 0, out[2]);
		end
		gate[2] = 1'b0;
		@(negedge ZCLK);
		check_value("square gate low", 1, out[2]);
		gate[2] = 1'b1;
		@(negedge ZCLK);
		check_value("square gate back", (cnt > SQ_INIT / 2) ? 1 : 0, out[2]);
		bus_write(CTRL_ADDR, latch_word(2'd2));
		read_pair("latch c2", 2'd2, cnt);
		// Live count of counter 2 moves away from its latched value
		tick(2);

		// MSB only after a full load so the lower half must clear
		b = 1 + int'({$random(seed)} % 255);
		bus_write(CTRL_ADDR, mode_word(2'd0, RW_MSB, 3'd0));
		bus_write(2'd0, b[7:0]);
		tick(0);
		bus_write(CTRL_ADDR, latch_word(2'd0));
		bus_read("msb only", 2'd0, 1'b0, 1'b1, rd);
		check_value("msb only high", b, rd);
		bus_write(CTRL_ADDR, mode_word(2'd0, RW_LSB, 3'd0));
		bus_read("msb only", 2'd0, 1'b0, 1'b1, rd);
		check_value("msb only low", 0, rd);

		// LSB only after an MSB load so the upper half must clear
		b = 1 + int'({$random(seed)} % 255);
		bus_write(2'd0, b[7:0]);
		tick(0);
		bus_write(CTRL_ADDR, latch_word(2'd0));
		bus_read("lsb only", 2'd0, 1'b0, 1'b1, rd);
		check_value("lsb only low", b, rd);
		bus_write(CTRL_ADDR, mode_word(2'd0, RW_MSB, 3'd0));
		bus_read("lsb only", 2'd0, 1'b0, 1'b1, rd);
		check_value("lsb only high", 0, rd);
		read_pair("keep c1", 2'd1, n1 - 2);
		read_pair("keep c2", 2'd2, cnt);

		// No drive for the control address or without chip select
		bus_read("oe addr3", CTRL_ADDR, 1'b0, 1'b0, rd);
		bus_read("oe no cs", 2'd1, 1'b1, 1'b0, rd);

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/pit_chk.sv ====
// Timer bus and output checks
`timescale 1ns/1ps
`default_nettype none

`include "pit_config.svh"

module pit_chk (
	input wire logic ZCLK,
	input wire logic rst_n,
	input wire logic cs_n,
	input wire logic rd_n,
	input wire logic data_oe,
	input wire logic [`PIT_NUM_COUNTERS-1:0] out
);

	// Output enable only during a selected read
	oe_needs_read: assert property (@(posedge ZCLK) disable iff (!rst_n)
		(rd_n || cs_n) |-> !data_oe)
		else $error("data_oe high without an active read");

	// Every channel idles high out of reset
	out_high_after_reset: assert property (@(posedge ZCLK)
		$rose(rst_n) |-> (&out))
		else $error("counter output low right after reset release");

endmodule

bind pit_top pit_chk u_pit_chk (
	.ZCLK(ZCLK),
	.rst_n(rst_n),
	.cs_n(cs_n),
	.rd_n(rd_n),
	.data_oe(data_oe),
	.out(out)
);

`default_nettype wire

// ==== design/pit_top.sv ====
// Interval timer top level
`timescale 1ns/1ps
`default_nettype none

`include "pit_config.svh"

module pit_top
	import pit_bus_pkg::*;
	import pit_count_pkg::*;
(
	input wire logic ZCLK,
	input wire logic rst_n,
	input wire logic cs_n,
	input wire logic rd_n,
	input wire logic wr_n,
	input wire logic [1:0] addr,
	input wire logic [`PIT_DATA_W-1:0] data_in,
	output logic [`PIT_DATA_W-1:0] data_out,
	output logic data_oe,
	input wire logic [`PIT_NUM_COUNTERS-1:0] timer_clk,
	input wire logic [`PIT_NUM_COUNTERS-1:0] gate,
	output logic [`PIT_NUM_COUNTERS-1:0] out
);

	host_bus_t bus;
	chan_access_t [`PIT_NUM_COUNTERS-1:0] chan;
	logic [`PIT_NUM_COUNTERS-1:0][`PIT_DATA_W-1:0] rd_byte;
	chan_load_t [`PIT_NUM_COUNTERS-1:0] load;
	logic [`PIT_NUM_COUNTERS-1:0][`PIT_COUNT_W-1:0] count_now;

	assign bus = '{cs_n: cs_n, rd_n: rd_n, wr_n: wr_n, addr: addr, data: data_in};

	bus_decoder u_bus_decoder (
		.ZCLK(ZCLK),
		.rst_n(rst_n),
		.bus(bus),
		.chan(chan),
		.rd_byte(rd_byte),
		.data_out(data_out),
		.data_oe(data_oe)
	);

	// One access block and one engine per counter
	for (genvar i = 0; i < `PIT_NUM_COUNTERS; i++) begin : g_chan
		count_access u_count_access (
			.ZCLK(ZCLK),
			.rst_n(rst_n),
			.acc(chan[i]),
			.count_now(count_now[i]),
			.load(load[i]),
			.rd_byte(rd_byte[i])
		);

		count_engine u_count_engine (
			.ZCLK(ZCLK),
			.rst_n(rst_n),
			.timer_clk(timer_clk[i]),
			.gate(gate[i]),
			.load(load[i]),
			.count_now(count_now[i]),
			.out(out[i])
		);
	end

endmodule

`default_nettype wire

// ==== counter/count_engine.sv ====
// Down counter and output waveform
`timescale 1ns/1ps
`default_nettype none

`include "pit_config.svh"

module count_engine
	import pit_count_pkg::*;
(
	input wire logic ZCLK,
	input wire logic rst_n,
	input wire logic timer_clk,
	input wire logic gate,
	input wire chan_load_t load,
	output logic [`PIT_COUNT_W-1:0] count_now,
	output logic out
);

	logic [`PIT_SYNC_STAGES-1:0] sync_q;
	logic clk_q;
	logic tick;
	logic pending_q;
	count_mode_t mode_q;
	logic [`PIT_COUNT_W-1:0] load_value;
	logic [`PIT_COUNT_W-1:0] init_q;
	logic [`PIT_COUNT_W-1:0] count_q;
	logic [`PIT_COUNT_W-1:0] half;

	// Timer clock into the ZCLK domain, one tick per rising edge
	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			sync_q <= '0;
			clk_q <= 1'b0;
		end else begin
			sync_q <= {sync_q[`PIT_SYNC_STAGES-2:0], timer_clk};
			clk_q <= sync_q[`PIT_SYNC_STAGES-1];
		end
	end

	assign tick = sync_q[`PIT_SYNC_STAGES-1] & ~clk_q;

	// Zero stands for the full range
	assign load_value = (load.count == '0) ? '1 : load.count;

	always_ff @(posedge ZCLK) begin
		if (load.pulse)
			init_q <= load_value;
	end

	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			pending_q <= 1'b0;
			mode_q <= MODE_TC;
			count_q <= '0;
		end else begin
			if (load.pulse) begin
				pending_q <= 1'b1;
				mode_q <= load.mode;
			end
			if (tick) begin
				if (pending_q && !load.pulse) begin
					count_q <= init_q;
					pending_q <= 1'b0;
				end else if (mode_q == MODE_SQUARE) begin
					count_q <= (count_q == '0) ? init_q : count_q - 1'b1;
				end else if (count_q != '0) begin
					// Terminal count holds at zero
					count_q <= count_q - 1'b1;
				end
			end
		end
	end

	assign count_now = count_q;
	assign half = {1'b0, init_q[`PIT_COUNT_W-1:1]};

	// Square wave is high over the upper half of the period
	always_comb begin
		if (mode_q == MODE_SQUARE)
			out = ~gate | (count_q > half);
		else
			out = ~pending_q & (count_q == '0);
	end

endmodule

`default_nettype wire

// ==== counter/count_access.sv ====
// Counter register access
`timescale 1ns/1ps
`default_nettype none

`include "pit_config.svh"

module count_access
	import pit_bus_pkg::*;
	import pit_count_pkg::*;
(
	input wire logic ZCLK,
	input wire logic rst_n,
	input wire chan_access_t acc,
	input wire logic [`PIT_COUNT_W-1:0] count_now,
	output chan_load_t load,
	output logic [`PIT_DATA_W-1:0] rd_byte
);

	ctrl_word_u ctrl;
	logic is_mode_cmd;
	logic final_byte;
	rw_order_t order_q;
	count_mode_t mode_q;
	logic msb_next_q;
	logic load_q;
	logic rd_msb_q;
	logic rd_hi;
	logic [`PIT_DATA_W-1:0] lsb_q;
	logic [`PIT_DATA_W-1:0] msb_q;
	logic [`PIT_COUNT_W-1:0] latch_q;

	assign ctrl = acc.data;
	assign is_mode_cmd = (rw_order_t'(ctrl.latch.zero) != RW_LATCH);

	// Last byte of the programmed order
	assign final_byte = acc.data_wr && ((order_q != RW_LSB_MSB) || msb_next_q);

	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			order_q <= RW_LSB_MSB;
			mode_q <= MODE_TC;
			msb_next_q <= 1'b0;
			load_q <= 1'b0;
			rd_msb_q <= 1'b0;
			latch_q <= '0;
		end else begin
			load_q <= final_byte;
			if (acc.ctrl_wr) begin
				rd_msb_q <= 1'b0;
				if (is_mode_cmd) begin
					// New mode aborts any half-written count
					order_q <= rw_order_t'(ctrl.mode.order);
					mode_q <= mode_from_field(ctrl.mode.mode);
					msb_next_q <= 1'b0;
				end else begin
					latch_q <= count_now;
				end
			end else begin
				if (acc.data_wr && (order_q == RW_LSB_MSB))
					msb_next_q <= ~msb_next_q;
				if (acc.rd && (order_q == RW_LSB_MSB))
					rd_msb_q <= ~rd_msb_q;
			end
		end
	end

	// Count bytes, the unwritten half is zero
	always_ff @(posedge ZCLK) begin
		if (acc.data_wr) begin
			case (order_q)
				RW_LSB: begin
					lsb_q <= acc.data;
					msb_q <= '0;
				end
				RW_MSB: begin
					msb_q <= acc.data;
					lsb_q <= '0;
				end
				default: begin
					if (msb_next_q)
						msb_q <= acc.data;
					else
						lsb_q <= acc.data;
				end
			endcase
		end
	end

	assign load.pulse = load_q;
	assign load.mode = mode_q;
	assign load.count = {msb_q, lsb_q};

	// Latched count in the same byte order as writes
	assign rd_hi = (order_q == RW_MSB) || ((order_q == RW_LSB_MSB) && rd_msb_q);
	assign rd_byte = rd_hi ? latch_q[`PIT_COUNT_W-1:`PIT_DATA_W] : latch_q[`PIT_DATA_W-1:0];

endmodule

`default_nettype wire

// ==== design/bus_decoder.sv ====
// Host bus decoder and read multiplexer
`timescale 1ns/1ps
`default_nettype none

`include "pit_config.svh"

module bus_decoder
	import pit_bus_pkg::*;
(
	input wire logic ZCLK,
	input wire logic rst_n,
	input wire host_bus_t bus,
	output chan_access_t [`PIT_NUM_COUNTERS-1:0] chan,
	input wire logic [`PIT_NUM_COUNTERS-1:0][`PIT_DATA_W-1:0] rd_byte,
	output logic [`PIT_DATA_W-1:0] data_out,
	output logic data_oe
);

	logic wr_n_q;
	logic rd_n_q;
	logic wr_fall;
	logic rd_fall;
	logic rd_any;
	logic [`PIT_DATA_W-1:0] rd_mux;
	ctrl_word_u ctrl;
	chan_access_t [`PIT_NUM_COUNTERS-1:0] chan_d;

	// Strobe edges only count while the chip is selected
	assign wr_fall = wr_n_q & ~bus.wr_n & ~bus.cs_n;
	assign rd_fall = rd_n_q & ~bus.rd_n & ~bus.cs_n;
	assign ctrl = bus.data;

	// Select value 3 matches no channel and is dropped
	always_comb begin
		for (int i = 0; i < `PIT_NUM_COUNTERS; i++) begin
			chan_d[i].ctrl_wr = wr_fall && (bus.addr == CTRL_ADDR) && (ctrl.mode.sel == i);
			chan_d[i].data_wr = wr_fall && (bus.addr == i);
			chan_d[i].rd = rd_fall && (bus.addr == i);
			chan_d[i].data = bus.data;
		end
	end

	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			wr_n_q <= 1'b1;
			rd_n_q <= 1'b1;
			chan <= '0;
		end else begin
			wr_n_q <= bus.wr_n;
			rd_n_q <= bus.rd_n;
			chan <= chan_d;
		end
	end

	// Byte of whichever channel sees a read pulse
	always_comb begin
		rd_any = 1'b0;
		rd_mux = '0;
		for (int i = 0; i < `PIT_NUM_COUNTERS; i++) begin
			if (chan[i].rd) begin
				rd_any = 1'b1;
				rd_mux = rd_byte[i];
			end
		end
	end

	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n)
			data_out <= '0;
		else if (rd_any)
			data_out <= rd_mux;
	end

	// Drive only for counter reads
	assign data_oe = ~bus.cs_n & ~bus.rd_n & (bus.addr != CTRL_ADDR);

endmodule

`default_nettype wire

// ==== common/pit_count_pkg.sv ====
// Counting types
`default_nettype none

`include "pit_config.svh"

package pit_count_pkg;

	// Byte order of count reads and writes
	typedef enum logic [1:0] {
		RW_LATCH = 2'b00,
		RW_LSB = 2'b01,
		RW_MSB = 2'b10,
		RW_LSB_MSB = 2'b11
	} rw_order_t;

	// Supported counting modes
	typedef enum logic {
		MODE_TC = 1'b0,
		MODE_SQUARE = 1'b1
	} count_mode_t;

	// Load request from the access side to the engine
	typedef struct packed {
		logic pulse;
		count_mode_t mode;
		logic [`PIT_COUNT_W-1:0] count;
	} chan_load_t;

	// Modes 3 and 7 give a square wave, everything else terminal count
	function automatic count_mode_t mode_from_field(logic [2:0] field);
		return (field[1:0] == 2'b11) ? MODE_SQUARE : MODE_TC;
	endfunction

endpackage

`default_nettype wire

// ==== common/pit_bus_pkg.sv ====
// Host bus types
`default_nettype none

`include "pit_config.svh"

package pit_bus_pkg;

	// Address of the control word register
	localparam logic [1:0] CTRL_ADDR = 2'd3;

	// One sampled host bus cycle
	typedef struct packed {
		logic cs_n;
		logic rd_n;
		logic wr_n;
		logic [1:0] addr;
		logic [`PIT_DATA_W-1:0] data;
	} host_bus_t;

	// Control word seen as a mode command
	typedef struct packed {
		logic [1:0] sel;
		logic [1:0] order;
		logic [2:0] mode;
		logic bcd;
	} mode_cmd_t;

	// Control word seen as a latch command, order field is zero
	typedef struct packed {
		logic [1:0] sel;
		logic [1:0] zero;
		logic [3:0] unused;
	} latch_cmd_t;

	// Order field decides which view applies
	typedef union packed {
		mode_cmd_t mode;
		latch_cmd_t latch;
	} ctrl_word_u;

	// Bus events for one channel in one cycle
	typedef struct packed {
		logic ctrl_wr;
		logic data_wr;
		logic rd;
		logic [`PIT_DATA_W-1:0] data;
	} chan_access_t;

endpackage

`default_nettype wire

// ==== common/pit_config.svh ====
// Timer configuration macros
`ifndef PIT_CONFIG_SVH
`define PIT_CONFIG_SVH

// Number of counter channels
`define PIT_NUM_COUNTERS 3

// Host data bus width
`define PIT_DATA_W 8

// Down counter width
`define PIT_COUNT_W 16

// Flops in the timer clock synchronizer
`define PIT_SYNC_STAGES 2

`endif
